// ==== hw/rvConfigPkg.sv ====
// Machine width and extension enables that decide which execute stage hardware is built
package rvConfigPkg;

  ////////////////////
  // Machine width
  ////////////////////
  localparam int Xlen    = 32;  // RV32 only, no W-suffix ops
  localparam int LogXlen = 5;   // Shift amount and bit index width

  ////////////////////
  // Bit-manipulation extensions
  ////////////////////
  // Clearing an enable removes that unit and turns its encodings illegal
  localparam bit ZbaEn = 1'b1;  // sh1add, sh2add, sh3add
  localparam bit ZbbEn = 1'b1;  // Basic bit manipulation
  localparam bit ZbcEn = 1'b1;  // Carry-less multiply
  localparam bit ZbsEn = 1'b1;  // Single-bit set, clear, invert, extract

endpackage

// ==== hw/aluOpsPkg.sv ====
// Request, control and response types and ALU select codes shared by the execute stage
package aluOpsPkg;
  import rvConfigPkg::*;

  ////////////////////
  // Port payloads
  ////////////////////
  typedef struct packed {
    logic            valid;     // Instruction present this cycle
    logic            isImm;     // OP-IMM when set, OP otherwise
    logic [2:0]      funct3;
    logic [6:0]      funct7;    // imm[11:5] for OP-IMM
    logic [4:0]      rs2Field;  // imm[4:0] for OP-IMM
    logic [Xlen-1:0] a;         // rs1 value
    logic [Xlen-1:0] b;         // rs2 value or sign-extended immediate, so b[4:0] tracks rs2Field
  } execReq_t;

  typedef struct packed {
    logic            valid;
    logic            illegal;   // Encoding not supported
    logic [Xlen-1:0] result;    // Zero when illegal
  } execResp_t;

  // Decoded controls handed from decoder to ALU
  typedef struct packed {
    logic       subArith;   // Invert B, add one, sign-fill right shifts
    logic       aluOp;      // Low forces plain add
    logic [2:0] aluSelect;  // Base result select
    logic [3:0] bSelect;    // One-hot ZBA_ZBB_ZBC_ZBS, zero for base
    logic [2:0] zbbSelect;  // Zbb result select
    logic [2:0] funct3;     // Raw funct3 for the sub-units
  } aluCtrl_t;

  ////////////////////
  // Select codes
  ////////////////////
  localparam logic [2:0] SelAdd   = 3'b000;  // add, sub, shNadd
  localparam logic [2:0] SelShift = 3'b001;  // Shifts and rotates
  localparam logic [2:0] SelSlt   = 3'b010;
  localparam logic [2:0] SelSltu  = 3'b011;
  localparam logic [2:0] SelXor   = 3'b100;  // xor, xnor, binv
  localparam logic [2:0] SelBext  = 3'b101;
  localparam logic [2:0] SelOr    = 3'b110;  // or, orn, bset
  localparam logic [2:0] SelAnd   = 3'b111;  // and, andn, bclr

  localparam logic [2:0] ZbbAndn   = 3'd0;   // Pass base result for andn/orn/xnor and rotates
  localparam logic [2:0] ZbbCount  = 3'd1;   // clz, ctz, cpop
  localparam logic [2:0] ZbbMinMax = 3'd2;
  localparam logic [2:0] ZbbExt    = 3'd3;   // sext.b, sext.h, zext.h
  localparam logic [2:0] ZbbRev8   = 3'd4;
  localparam logic [2:0] ZbbOrcb   = 3'd5;

  localparam logic [3:0] BSelZbs = 4'b0001;
  localparam logic [3:0] BSelZbc = 4'b0010;
  localparam logic [3:0] BSelZbb = 4'b0100;
  localparam logic [3:0] BSelZba = 4'b1000;

  // Bit order reversal, used by the shifter and the zero counters
  function automatic logic [Xlen-1:0] bitRev(input logic [Xlen-1:0] x);
    logic [Xlen-1:0] r;
    for (int i = 0; i < Xlen; i++) begin
      r[i] = x[Xlen-1-i];
    end
    return r;
  endfunction

endpackage

// ==== hw/shifter.sv ====
// Barrel shifter for sll/srl/sra and the Zbb rotates, built around a single right shift
`timescale 1ns/1ns

module shifter
  import rvConfigPkg::*, aluOpsPkg::*;
(
  input  logic [Xlen:0]      shA,     // Operand with sign or zero fill bit on top
  input  logic [Xlen-1:0]    rotA,    // Rotate source
  input  logic [LogXlen-1:0] amt,
  input  logic               right,
  input  logic               rotate,
  output logic [Xlen-1:0]    y
);

  logic [Xlen-1:0]   srcSel;   // Shift or rotate operand
  logic [Xlen-1:0]   src;      // Bit reversed for left moves
  logic              fill;     // Sign fill for sra
  logic [2*Xlen-1:0] wide;     // Fill or doubled operand above source
  logic [2*Xlen-1:0] wideSh;
  logic [Xlen-1:0]   shOut;

  assign srcSel = rotate ? rotA : shA[Xlen-1:0];

  // Left shift becomes right shift of the reversed word
  assign src = right ? srcSel : bitRev(srcSel);

  // Only arithmetic right shifts pull in the sign
  assign fill = right & shA[Xlen] & ~rotate;

  // Doubling makes bits shifted out reappear on top
  assign wide = rotate ? {src, src} : {{Xlen{fill}}, src};

  assign wideSh = wide >> amt;         // The one and only shift
  assign shOut  = wideSh[Xlen-1:0];

  // Undo the reversal for left moves
  assign y = right ? shOut : bitRev(shOut);

endmodule

// ==== hw/zbbUnit.sv ====
// Zbb result generation for counts, min/max, extensions, rev8, orc.b and inverted logic ops
`timescale 1ns/1ns

module zbbUnit
  import rvConfigPkg::*, aluOpsPkg::*;
(
  input  logic [Xlen-1:0] a,
  input  logic [Xlen-1:0] b,
  input  logic [Xlen-1:0] baseResult,  // andn/orn/xnor and rotates come from the base path
  input  logic            lt,          // Signed or unsigned a < b, picked by the ALU
  input  logic [2:0]      zbbSelect,
  input  logic [2:0]      funct3,
  input  logic [4:0]      rs2Field,
  output logic [Xlen-1:0] y
);

  logic [Xlen-1:0] cntSrc;    // Reversed for clz
  logic [Xlen-1:0] cntMask;   // Ones to be counted
  logic [LogXlen:0] popCnt;   // Up to Xlen
  logic [Xlen-1:0] cntOut;
  logic [Xlen-1:0] minMax;
  logic [Xlen-1:0] extOut;
  logic [Xlen-1:0] byteRev;
  logic [Xlen-1:0] orComb;

  ////////////////////
  // Counts share one popcount
  ////////////////////
  assign cntSrc = rs2Field[0] ? a : bitRev(a);  // ctz on a, clz on reversed a

  // Trailing zeros turn into a run of ones, cpop keeps a as is
  assign cntMask = rs2Field[1] ? a : (~cntSrc & (cntSrc - Xlen'(1)));

  always_comb begin
    popCnt = '0;
    for (int i = 0; i < Xlen; i++) begin
      popCnt = popCnt + {{LogXlen{1'b0}}, cntMask[i]};
    end
  end

  assign cntOut = {{(Xlen-LogXlen-1){1'b0}}, popCnt};

  // min/minu keep a when lower, max/maxu keep b
  assign minMax = (lt ^ funct3[1]) ? a : b;

  always_comb begin
    if (funct3[2]) begin
      extOut = {{(Xlen-16){1'b0}}, a[15:0]};      // zext.h
    end else if (rs2Field[0]) begin
      extOut = {{(Xlen-16){a[15]}}, a[15:0]};     // sext.h
    end else begin
      extOut = {{(Xlen-8){a[7]}}, a[7:0]};        // sext.b
    end
  end

  // Per byte work for rev8 and orc.b
  always_comb begin
    for (int k = 0; k < Xlen/8; k++) begin
      byteRev[8*k +: 8] = a[Xlen-8-8*k +: 8];
      orComb[8*k +: 8]  = {8{|a[8*k +: 8]}};
    end
  end

  always_comb begin
    case (zbbSelect)
      ZbbAndn:   y = baseResult;
      ZbbCount:  y = cntOut;
      ZbbMinMax: y = minMax;
      ZbbExt:    y = extOut;
      ZbbRev8:   y = byteRev;
      ZbbOrcb:   y = orComb;
      default:   y = '0;
    endcase
  end

endmodule

// ==== hw/zbcUnit.sv ====
// Carry-less multiply for clmul, clmulh and clmulr from one full-width product
`timescale 1ns/1ns

module zbcUnit
  import rvConfigPkg::*;
(
  input  logic [Xlen-1:0] a,
  input  logic [Xlen-1:0] b,
  input  logic [2:0]      funct3,
  output logic [Xlen-1:0] y
);

  logic [2*Xlen-1:0] prod;  // Full carry-less product

  // XOR together a shifted copy of a for every set bit of b
  always_comb begin
    prod = '0;
    for (int i = 0; i < Xlen; i++) begin
      if (b[i]) begin
        prod = prod ^ ({{Xlen{1'b0}}, a} << i);
      end
    end
  end

  // funct3 low bits pick the product window
  always_comb begin
    case (funct3[1:0])
      2'b01:   y = prod[Xlen-1:0];          // clmul
      2'b11:   y = prod[2*Xlen-1:Xlen];     // clmulh
      2'b10:   y = prod[2*Xlen-2:Xlen-1];   // clmulr
      default: y = '0;
    endcase
  end

endmodule

// ==== hw/aluDecoder.sv ====
// Combinational decode of OP/OP-IMM funct fields into ALU controls with an illegal flag
`timescale 1ns/1ns

module aluDecoder
  import rvConfigPkg::*, aluOpsPkg::*;
(
  input  logic       isImm,
  input  logic [2:0] funct3,
  input  logic [6:0] funct7,
  input  logic [4:0] rs2Field,
  output aluCtrl_t   ctrl,
  output logic       illegal
);

  logic legal;   // Encoding matched a table row
  logic extOff;  // Matched row belongs to a disabled extension

  // One table row worth of controls
  function automatic aluCtrl_t mk(input logic [2:0] sel, input logic sub,
                                  input logic [3:0] bs, input logic [2:0] zs);
    aluCtrl_t c;
    c = '{subArith: sub, aluOp: 1'b1, aluSelect: sel, bSelect: bs,
          zbbSelect: zs, funct3: 3'b000};
    return c;
  endfunction

  always_comb begin
    legal = 1'b1;
    ctrl  = mk(SelAdd, 1'b0, 4'b0000, ZbbAndn);
    casez ({isImm, funct7, funct3})
      ////////////////////
      // OP-IMM, funct7 is immediate except for shifts
      ////////////////////
      11'b1_???????_000: ctrl = mk(SelAdd, 1'b0, 4'b0000, ZbbAndn);   // addi
      11'b1_???????_010: ctrl = mk(SelSlt, 1'b1, 4'b0000, ZbbAndn);   // slti
      11'b1_???????_011: ctrl = mk(SelSltu, 1'b1, 4'b0000, ZbbAndn);  // sltiu
      11'b1_???????_100: ctrl = mk(SelXor, 1'b0, 4'b0000, ZbbAndn);
      11'b1_???????_110: ctrl = mk(SelOr, 1'b0, 4'b0000, ZbbAndn);
      11'b1_???????_111: ctrl = mk(SelAnd, 1'b0, 4'b0000, ZbbAndn);
      11'b1_0000000_001: ctrl = mk(SelShift, 1'b0, 4'b0000, ZbbAndn); // slli
      11'b1_0000000_101: ctrl = mk(SelShift, 1'b0, 4'b0000, ZbbAndn); // srli
      11'b1_0100000_101: ctrl = mk(SelShift, 1'b1, 4'b0000, ZbbAndn); // srai
      11'b1_0010100_001: ctrl = mk(SelOr, 1'b0, BSelZbs, ZbbAndn);    // bseti
      11'b1_0100100_001: ctrl = mk(SelAnd, 1'b1, BSelZbs, ZbbAndn);   // bclri
      11'b1_0110100_001: ctrl = mk(SelXor, 1'b0, BSelZbs, ZbbAndn);   // binvi
      11'b1_0100100_101: ctrl = mk(SelBext, 1'b0, BSelZbs, ZbbAndn);  // bexti
      11'b1_0110000_101: ctrl = mk(SelShift, 1'b0, BSelZbb, ZbbAndn); // rori
      11'b1_0110000_001: begin  // Unary Zbb picked by rs2 field
        ctrl  = mk(SelAdd, 1'b0, BSelZbb, rs2Field[2] ? ZbbExt : ZbbCount);
        legal = rs2Field inside {5'd0, 5'd1, 5'd2, 5'd4, 5'd5};
      end
      11'b1_0010100_101: begin
        ctrl  = mk(SelAdd, 1'b0, BSelZbb, ZbbOrcb);
        legal = (rs2Field == 5'b00111);  // orc.b
      end
      11'b1_0110100_101: begin
        ctrl  = mk(SelAdd, 1'b0, BSelZbb, ZbbRev8);
        legal = (rs2Field == 5'b11000);  // rev8, RV32 form
      end
      ////////////////////
      // OP
      ////////////////////
      11'b0_0000000_000: ctrl = mk(SelAdd, 1'b0, 4'b0000, ZbbAndn);
      11'b0_0000000_001: ctrl = mk(SelShift, 1'b0, 4'b0000, ZbbAndn); // sll
      11'b0_0000000_010: ctrl = mk(SelSlt, 1'b1, 4'b0000, ZbbAndn);
      11'b0_0000000_011: ctrl = mk(SelSltu, 1'b1, 4'b0000, ZbbAndn);
      11'b0_0000000_100: ctrl = mk(SelXor, 1'b0, 4'b0000, ZbbAndn);
      11'b0_0000000_101: ctrl = mk(SelShift, 1'b0, 4'b0000, ZbbAndn); // srl
      11'b0_0000000_110: ctrl = mk(SelOr, 1'b0, 4'b0000, ZbbAndn);
      11'b0_0000000_111: ctrl = mk(SelAnd, 1'b0, 4'b0000, ZbbAndn);
      11'b0_0100000_000: ctrl = mk(SelAdd, 1'b1, 4'b0000, ZbbAndn);   // sub
      11'b0_0100000_101: ctrl = mk(SelShift, 1'b1, 4'b0000, ZbbAndn); // sra
      11'b0_0100000_100: ctrl = mk(SelXor, 1'b1, BSelZbb, ZbbAndn);   // xnor
      11'b0_0100000_110: ctrl = mk(SelOr, 1'b1, BSelZbb, ZbbAndn);    // orn
      11'b0_0100000_111: ctrl = mk(SelAnd, 1'b1, BSelZbb, ZbbAndn);   // andn
      11'b0_0110000_?01: ctrl = mk(SelShift, 1'b0, BSelZbb, ZbbAndn); // rol, ror
      11'b0_0000101_1??: ctrl = mk(SelAdd, 1'b1, BSelZbb, ZbbMinMax); // Compare via sub
      11'b0_0000101_001,
      11'b0_0000101_010,
      11'b0_0000101_011: ctrl = mk(SelAdd, 1'b0, BSelZbc, ZbbAndn);   // clmul family
      11'b0_0010000_010,
      11'b0_0010000_100,
      11'b0_0010000_110: ctrl = mk(SelAdd, 1'b0, BSelZba, ZbbAndn);   // shNadd
      11'b0_0010100_001: ctrl = mk(SelOr, 1'b0, BSelZbs, ZbbAndn);    // bset
      11'b0_0100100_001: ctrl = mk(SelAnd, 1'b1, BSelZbs, ZbbAndn);   // bclr
      11'b0_0110100_001: ctrl = mk(SelXor, 1'b0, BSelZbs, ZbbAndn);   // binv
      11'b0_0100100_101: ctrl = mk(SelBext, 1'b0, BSelZbs, ZbbAndn);  // bext
      11'b0_0000100_100: begin
        ctrl  = mk(SelAdd, 1'b0, BSelZbb, ZbbExt);
        legal = (rs2Field == 5'b00000);  // zext.h
      end
      default: legal = 1'b0;  // M extension and unknown rows land here
    endcase
    extOff       = |(ctrl.bSelect & ~{ZbaEn, ZbbEn, ZbcEn, ZbsEn});
    illegal      = ~legal | extOff;
    ctrl.funct3  = funct3;
    ctrl.aluOp   = ~illegal;
  end

  // Legal OP rows outside the base funct7 values belong to an extension unit
  always_comb begin
    if (!isImm && !illegal && !(funct7 inside {7'h00, 7'h20})) begin
      assert (ctrl.bSelect != 4'b0000)
        else $error("aluDecoder OP funct7 %h left on the base path", funct7);
    end
  end

endmodule

// ==== hw/alu.sv ====
// Integer ALU with adder, compares, logic, single-bit ops, Zba pre-shift and extension units
`timescale 1ns/1ns

module alu
  import rvConfigPkg::*, aluOpsPkg::*;
(
  input  logic [Xlen-1:0] a,
  input  logic [Xlen-1:0] b,
  input  aluCtrl_t        ctrl,
  output logic [Xlen-1:0] result
);

  logic [Xlen-1:0] maskB;       // One-hot from b[4:0]
  logic [Xlen-1:0] condMaskB;   // Mask for Zbs, b otherwise
  logic [Xlen-1:0] condInvB;
  logic [Xlen-1:0] condShiftA;  // a after Zba pre-shift
  logic [Xlen-1:0] sum;
  logic [Xlen-1:0] shiftOut;
  logic [Xlen-1:0] fullResult;  // Base result before the extension mux
  logic [Xlen-1:0] zbbResult;
  logic [Xlen-1:0] zbcResult;
  logic [Xlen:0]   shA;         // Sign or zero fill for right shifts
  logic [Xlen-1:0] rotA;
  logic            carry, neg, lt, ltu;
  logic            rotate;

  ////////////////////
  // Operand prep
  ////////////////////
  assign maskB     = Xlen'(1) << b[LogXlen-1:0];
  assign condMaskB = (ZbsEn && ctrl.bSelect[0]) ? maskB : b;
  assign condInvB  = ctrl.subArith ? ~condMaskB : condMaskB;
  assign shA       = ctrl.subArith ? {a[Xlen-1], a} : {1'b0, a};
  assign rotA      = a;  // RV32 rotates the full word

  // sh1add/sh2add/sh3add scale a by funct3[2:1]
  always_comb begin
    case (ctrl.funct3[2:1] & {2{ZbaEn && ctrl.bSelect[3]}})
      2'b01:   condShiftA = {a[Xlen-2:0], 1'b0};
      2'b10:   condShiftA = {a[Xlen-3:0], 2'b00};
      2'b11:   condShiftA = {a[Xlen-4:0], 3'b000};
      default: condShiftA = a;
    endcase
  end

  assign {carry, sum} = {1'b0, condShiftA} + {1'b0, condInvB} + (Xlen+1)'(ctrl.subArith);

  // Flags from a - b
  assign neg = sum[Xlen-1];
  assign lt  = a[Xlen-1] & ~b[Xlen-1] | a[Xlen-1] & neg | ~b[Xlen-1] & neg;
  assign ltu = ~carry;  // No carry out means a borrow

  assign rotate = ZbbEn && ctrl.bSelect[2] && (ctrl.aluSelect == SelShift);

  shifter shifter_i (
    .shA(shA), .rotA(rotA), .amt(b[LogXlen-1:0]),
    .right(ctrl.funct3[2]), .rotate(rotate), .y(shiftOut)
  );

  always_comb begin
    if (!ctrl.aluOp) begin
      fullResult = sum;  // Illegal decode falls back to add
    end else begin
      case (ctrl.aluSelect)
        SelAdd:   fullResult = sum;
        SelShift: fullResult = shiftOut;
        SelSlt:   fullResult = {{(Xlen-1){1'b0}}, lt};
        SelSltu:  fullResult = {{(Xlen-1){1'b0}}, ltu};
        SelXor:   fullResult = a ^ condInvB;   // xor, xnor, binv
        SelBext:  fullResult = {{(Xlen-1){1'b0}}, |(a & condMaskB)};
        SelOr:    fullResult = a | condInvB;   // or, orn, bset
        default:  fullResult = a & condInvB;   // and, andn, bclr
      endcase
    end
  end

  ////////////////////
  // Extension units
  ////////////////////
  if (ZbbEn) begin : gZbb
    zbbUnit zbbUnit_i (
      .a(a), .b(b), .baseResult(fullResult), .lt(ctrl.funct3[0] ? ltu : lt),
      .zbbSelect(ctrl.zbbSelect), .funct3(ctrl.funct3), .rs2Field(b[4:0]), .y(zbbResult)
    );
  end else begin : gNoZbb
    assign zbbResult = '0;
  end

  if (ZbcEn) begin : gZbc
    zbcUnit zbcUnit_i (.a(a), .b(b), .funct3(ctrl.funct3), .y(zbcResult));
  end else begin : gNoZbc
    assign zbcResult = '0;
  end

  // Final pick on the one-hot extension select
  always_comb begin
    case (ctrl.bSelect)
      BSelZbs: result = fullResult;
      BSelZbc: result = zbcResult;
      BSelZbb: result = zbbResult;
      BSelZba: result = fullResult;  // Sum of pre-shifted a
      default: result = fullResult;
    endcase
  end

endmodule

// ==== hw/executeStage.sv ====
// Execute stage top joining decoder and ALU behind one response register, one cycle latency
`timescale 1ns/1ns

module executeStage
  import rvConfigPkg::*, aluOpsPkg::*;
(
  input  logic      clk,
  input  logic      arstN,
  input  execReq_t  req,
  output execResp_t resp
);

  aluCtrl_t        ctrl;
  logic            illegal;
  logic [Xlen-1:0] aluResult;
  logic            validQ;
  logic            illegalQ;
  logic [Xlen-1:0] resultQ;

  aluDecoder aluDecoder_i (
    .isImm(req.isImm), .funct3(req.funct3), .funct7(req.funct7),
    .rs2Field(req.rs2Field), .ctrl(ctrl), .illegal(illegal)
  );

  alu alu_i (.a(req.a), .b(req.b), .ctrl(ctrl), .result(aluResult));

  ////////////////////
  // Response register
  ////////////////////
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      validQ <= 1'b0;
    end else begin
      validQ <= req.valid;  // Strobe follows the request by one cycle
    end
  end

  // Payload only moves with a valid request
  always_ff @(posedge clk) begin
    if (req.valid) begin
      illegalQ <= illegal;
      resultQ  <= illegal ? '0 : aluResult;  // Illegal ops report zero
    end
  end

  assign resp = '{valid: validQ, illegal: illegalQ, result: resultQ};

  // No response may leak out of the reset period
  property pIdleAfterReset;
    @(posedge clk) $rose(arstN) |-> !resp.valid;
  endproperty
  aIdleAfterReset: assert property (pIdleAfterReset)
    else $error("resp.valid high in the first cycle after reset");

endmodule

// ==== verif/execChecker.sv ====
// Testbench monitor that predicts each execute stage response and compares it one cycle later
`timescale 1ns/1ns

module execChecker
  import rvConfigPkg::*, aluOpsPkg::*;
(
  input  logic       clk,
  input  logic       arstN,
  input  execReq_t   req,
  input  execResp_t  resp,
  input  logic [127:0] testTag,     // ASCII name of the running test
  output int         mismatchCount,
  output int         protocolCount
);

  logic [32:0]  expQ[$];  // {illegal, result} per pending request
  logic [127:0] tagQ[$];
  logic [32:0]  expNow;
  logic [127:0] tagNow;

  ////////////////////
  // Spec helpers
  ////////////////////
  function automatic int countLeadZeros(input logic [31:0] x);
    int n;
    logic found;
    n = 0;
    found = 1'b0;
    for (int i = 31; i >= 0; i--) begin
      if (x[i]) found = 1'b1;
      else if (!found) n++;
    end
    return n;
  endfunction

  function automatic int countTrailZeros(input logic [31:0] x);
    int n;
    logic found;
    n = 0;
    found = 1'b0;
    for (int i = 0; i < 32; i++) begin
      if (x[i]) found = 1'b1;
      else if (!found) n++;
    end
    return n;
  endfunction

  function automatic int countOnes(input logic [31:0] x);
    int n;
    n = 0;
    for (int i = 0; i < 32; i++) n += int'(x[i]);
    return n;
  endfunction

  // Full carry-less product, walking the bits of x
  function automatic logic [63:0] carrylessProduct(input logic [31:0] x, input logic [31:0] y);
    logic [63:0] p;
    p = '0;
    for (int i = 0; i < 32; i++) begin
      if (x[i]) p ^= ({32'd0, y} << i);
    end
    return p;
  endfunction

  function automatic logic [31:0] rotLeft(input logic [31:0] x, input logic [4:0] n);
    logic [63:0] t;
    t = {x, x} << n;
    return t[63:32];
  endfunction

  function automatic logic [31:0] rotRight(input logic [31:0] x, input logic [4:0] n);
    logic [63:0] t;
    t = {x, x} >> n;
    return t[31:0];
  endfunction

  ////////////////////
  // Reference model of OP and OP-IMM
  ////////////////////
  function automatic logic [32:0] refExec(input logic isImm, input logic [2:0] f3,
                                          input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [31:0] a, input logic [31:0] b);
    logic [31:0] r;
    logic        ok;
    logic [4:0]  sh;
    logic [63:0] p;
    r  = '0;
    ok = 1'b1;
    sh = b[4:0];  // Shift amount or bit index
    p  = carrylessProduct(a, b);
    if (isImm) begin
      case (f3)
        3'd0: r = a + b;
        3'd2: r = {31'd0, $signed(a) < $signed(b)};
        3'd3: r = {31'd0, a < b};
        3'd4: r = a ^ b;
        3'd6: r = a | b;
        3'd7: r = a & b;
        3'd1: begin
          case (f7)
            7'h00: r = a << sh;                 // slli
            7'h14: r = a | (32'd1 << sh);       // bseti
            7'h24: r = a & ~(32'd1 << sh);      // bclri
            7'h34: r = a ^ (32'd1 << sh);       // binvi
            7'h30: begin
              case (rs2)
                5'd0:    r = countLeadZeros(a);
                5'd1:    r = countTrailZeros(a);
                5'd2:    r = countOnes(a);
                5'd4:    r = {{24{a[7]}}, a[7:0]};
                5'd5:    r = {{16{a[15]}}, a[15:0]};
                default: ok = 1'b0;
              endcase
            end
            default: ok = 1'b0;
          endcase
        end
        default: begin  // funct3 101
          case (f7)
            7'h00: r = a >> sh;
            7'h20: r = $unsigned($signed(a) >>> sh);
            7'h24: r = (a >> sh) & 32'd1;       // bexti
            7'h30: r = rotRight(a, sh);         // rori
            7'h14: begin
              ok = (rs2 == 5'd7);               // orc.b
              for (int k = 0; k < 4; k++) r[8*k +: 8] = {8{|a[8*k +: 8]}};
            end
            7'h34: begin
              ok = (rs2 == 5'd24);              // rev8
              r  = {a[7:0], a[15:8], a[23:16], a[31:24]};
            end
            default: ok = 1'b0;
          endcase
        end
      endcase
    end else begin
      case (f7)
        7'h00: begin
          case (f3)
            3'd0: r = a + b;
            3'd1: r = a << sh;
            3'd2: r = {31'd0, $signed(a) < $signed(b)};
            3'd3: r = {31'd0, a < b};
            3'd4: r = a ^ b;
            3'd5: r = a >> sh;
            3'd6: r = a | b;
            default: r = a & b;
          endcase
        end
        7'h20: begin
          case (f3)
            3'd0:    r = a - b;
            3'd5:    r = $unsigned($signed(a) >>> sh);
            3'd4:    r = ~(a ^ b);              // xnor
            3'd6:    r = a | ~b;                // orn
            3'd7:    r = a & ~b;                // andn
            default: ok = 1'b0;
          endcase
        end
        7'h30: begin
          if (f3 == 3'd1) r = rotLeft(a, sh);
          else if (f3 == 3'd5) r = rotRight(a, sh);
          else ok = 1'b0;
        end
        7'h05: begin
          case (f3)
            3'd1:    r = p[31:0];               // clmul
            3'd2:    r = p[62:31];              // clmulr
            3'd3:    r = p[63:32];              // clmulh
            3'd4:    r = ($signed(a) < $signed(b)) ? a : b;
            3'd5:    r = (a < b) ? a : b;
            3'd6:    r = ($signed(a) < $signed(b)) ? b : a;
            3'd7:    r = (a < b) ? b : a;
            default: ok = 1'b0;
          endcase
        end
        7'h10: begin  // shNadd
          if (f3 == 3'd2) r = (a << 1) + b;
          else if (f3 == 3'd4) r = (a << 2) + b;
          else if (f3 == 3'd6) r = (a << 3) + b;
          else ok = 1'b0;
        end
        7'h14: begin
          if (f3 == 3'd1) r = a | (32'd1 << sh);
          else ok = 1'b0;
        end
        7'h24: begin
          if (f3 == 3'd1) r = a & ~(32'd1 << sh);
          else if (f3 == 3'd5) r = (a >> sh) & 32'd1;
          else ok = 1'b0;
        end
        7'h34: begin
          if (f3 == 3'd1) r = a ^ (32'd1 << sh);
          else ok = 1'b0;
        end
        7'h04: begin
          ok = (f3 == 3'd4) && (rs2 == 5'd0);   // zext.h
          r  = {16'd0, a[15:0]};
        end
        default: ok = 1'b0;  // M extension and reserved rows
      endcase
    end
    if (!ok) r = '0;
    return {~ok, r};
  endfunction

  ////////////////////
  // Compare at the falling edge, away from the DUT clock edge
  ////////////////////
  initial begin
    mismatchCount = 0;
    protocolCount = 0;
  end

  always @(negedge clk) begin
    if (arstN) begin
      if (resp.valid === 1'b1) begin
        if (expQ.size() == 0) begin
          $display("ERROR: response valid without a request in the previous cycle");
          protocolCount++;
        end else begin
          expNow = expQ.pop_front();
          tagNow = tagQ.pop_front();
          if (resp.illegal !== expNow[32]) begin
            $display("MISMATCH %0s illegal expected %0b actual %0b",
                     tagNow, expNow[32], resp.illegal);
            mismatchCount++;
          end
          if (resp.result !== expNow[31:0]) begin
            $display("MISMATCH %0s result expected %08h actual %08h",
                     tagNow, expNow[31:0], resp.result);
            mismatchCount++;
          end
        end
      end else if (resp.valid !== 1'b0) begin
        $display("ERROR: response valid is unknown");
        protocolCount++;
      end else if (expQ.size() != 0) begin
        $display("ERROR: response missing one cycle after a %0s request", tagQ[0]);
        protocolCount++;
        expNow = expQ.pop_front();
        tagNow = tagQ.pop_front();
      end
      if (req.valid) begin  // Stable here, sampled by the next rising edge
        expQ.push_back(refExec(req.isImm, req.funct3, req.funct7, req.rs2Field, req.a, req.b));
        tagQ.push_back(testTag);
      end
    end
  end

endmodule

// ==== verif/tbExecute.sv ====
// Testbench top for the execute stage, drives directed and random instructions into the DUT
`timescale 1ns/1ns

module tbExecute
  import rvConfigPkg::*, aluOpsPkg::*;
();

  ////////////////////
  // Run length
  ////////////////////
  localparam int NumBase     = 304;  // 10 OP ops and 9 OP-IMM ops, 16 operand pairs each
  localparam int NumZba      = 60;
  localparam int NumZbs      = 256;  // 4 ops, 2 forms, 32 bit indexes
  localparam int NumZbb      = 360;
  localparam int NumZbc      = 90;
  localparam int NumIllegal  = 100;
  localparam int GapCycles   = 100;  // One idle cycle after each random encoding
  localparam int ResetCycles = 5;
  localparam int CycleLimit  = NumBase + NumZba + NumZbs + NumZbb + NumZbc + NumIllegal
                               + GapCycles + ResetCycles + 50;

  logic         clk;
  logic         arstN;
  execReq_t     req;
  execResp_t    resp;
  logic [127:0] testTag;
  int           seed;
  int           cycles;
  int           mismatchCount;
  int           protocolCount;
  logic [31:0]  x;
  logic [31:0]  y;
  logic [31:0]  r;

  logic [31:0] corners[4] = '{32'h0000_0000, 32'hffff_ffff, 32'h8000_0000, 32'h7fff_ffff};
  logic [11:0] immCorners[4] = '{12'h000, 12'hfff, 12'h7ff, 12'h800};
  logic [4:0]  shamts[4] = '{5'd0, 5'd1, 5'd17, 5'd31};

  executeStage dut_i (.clk(clk), .arstN(arstN), .req(req), .resp(resp));

  execChecker checker_i (
    .clk(clk), .arstN(arstN), .req(req), .resp(resp), .testTag(testTag),
    .mismatchCount(mismatchCount), .protocolCount(protocolCount)
  );

  initial clk = 1'b0;
  always #4 clk = ~clk;  // 8 ns period

  always @(posedge clk) begin
    cycles++;
    if (cycles >= CycleLimit) begin
      $display("ERROR: run did not finish within %0d cycles", CycleLimit);
      $display("=== FAIL ===");
      $finish;
    end
  end

  ////////////////////
  // Drive helpers
  ////////////////////
  function automatic logic [31:0] rand32();
    return $random(seed);
  endfunction

  task automatic sendOp(input logic isImm, input logic [2:0] f3, input logic [6:0] f7,
                        input logic [4:0] rs2, input logic [31:0] a, input logic [31:0] b);
    @(posedge clk);
    #1;
    req = '{valid: 1'b1, isImm: isImm, funct3: f3, funct7: f7, rs2Field: rs2, a: a, b: b};
  endtask

  // Register form, rs2 field follows the operand's low bits
  task automatic sendReg(input logic [6:0] f7, input logic [2:0] f3,
                         input logic [31:0] a, input logic [31:0] b);
    sendOp(1'b0, f3, f7, b[4:0], a, b);
  endtask

  task automatic sendImm(input logic [2:0] f3, input logic [11:0] imm, input logic [31:0] a);
    sendOp(1'b1, f3, imm[11:5], imm[4:0], a, {{20{imm[11]}}, imm});
  endtask

  task automatic idleCycles(input int n);
    repeat (n) begin
      @(posedge clk);
      #1;
      req.valid = 1'b0;
    end
  endtask

  initial begin
    seed    = 63507;
    cycles  = 0;
    req     = '0;
    testTag = "reset";
    arstN   = 1'b0;
    repeat (ResetCycles) @(posedge clk);
    #1 arstN = 1'b1;

    ////////////////////
    // Base RV32I on corner operands
    ////////////////////
    testTag = "rv32i";
    for (int i = 0; i < 4; i++) begin
      for (int j = 0; j < 4; j++) begin
        for (int f = 0; f < 8; f++) sendReg(7'h00, f[2:0], corners[i], corners[j]);
        sendReg(7'h20, 3'd0, corners[i], corners[j]);  // sub
        sendReg(7'h20, 3'd5, corners[i], corners[j]);  // sra
        sendImm(3'd0, immCorners[j], corners[i]);
        sendImm(3'd2, immCorners[j], corners[i]);
        sendImm(3'd3, immCorners[j], corners[i]);
        sendImm(3'd4, immCorners[j], corners[i]);
        sendImm(3'd6, immCorners[j], corners[i]);
        sendImm(3'd7, immCorners[j], corners[i]);
        sendImm(3'd1, {7'h00, shamts[j]}, corners[i]);
        sendImm(3'd5, {7'h00, shamts[j]}, corners[i]);
        sendImm(3'd5, {7'h20, shamts[j]}, corners[i]);
      end
    end

    testTag = "zba";
    for (int k = 0; k < 20; k++) begin
      sendReg(7'h10, 3'd2, rand32(), rand32());
      sendReg(7'h10, 3'd4, rand32(), rand32());
      sendReg(7'h10, 3'd6, rand32(), rand32());
    end

    testTag = "zbs";
    for (int idx = 0; idx < 32; idx++) begin
      x = rand32();
      y = {27'(rand32()), idx[4:0]};  // Upper bits must not matter
      sendReg(7'h14, 3'd1, x, y);
      sendImm(3'd1, {7'h14, idx[4:0]}, x);
      sendReg(7'h24, 3'd1, x, y);
      sendImm(3'd1, {7'h24, idx[4:0]}, x);
      sendReg(7'h34, 3'd1, x, y);
      sendImm(3'd1, {7'h34, idx[4:0]}, x);
      sendReg(7'h24, 3'd5, x, y);
      sendImm(3'd5, {7'h24, idx[4:0]}, x);
    end

    ////////////////////
    // Zbb
    ////////////////////
    testTag = "zbb";
    for (int k = 0; k < 20; k++) begin
      x = (k == 0) ? 32'd0 : rand32();  // Zero input for the counters
      y = (k == 1) ? x : rand32();      // Equal operands for min/max
      sendImm(3'd1, {7'h30, 5'd0}, x);  // clz
      sendImm(3'd1, {7'h30, 5'd1}, x);  // ctz
      sendImm(3'd1, {7'h30, 5'd2}, x);  // cpop
      sendImm(3'd1, {7'h30, 5'd4}, x);  // sext.b
      sendImm(3'd1, {7'h30, 5'd5}, x);  // sext.h
      sendImm(3'd5, {7'h14, 5'd7}, x);  // orc.b
      sendImm(3'd5, {7'h34, 5'd24}, x); // rev8
      sendReg(7'h04, 3'd4, x, 32'd0);   // zext.h
      for (int f = 4; f < 8; f++) sendReg(7'h05, f[2:0], x, y);
      sendReg(7'h30, 3'd1, x, y);       // rol
      sendReg(7'h30, 3'd5, x, y);       // ror
      sendImm(3'd5, {7'h30, y[4:0]}, x);
      sendReg(7'h20, 3'd7, x, y);
      sendReg(7'h20, 3'd6, x, y);
      sendReg(7'h20, 3'd4, x, y);
    end

    testTag = "zbc";
    for (int k = 0; k < 30; k++) begin
      sendReg(7'h05, 3'd1, rand32(), rand32());
      sendReg(7'h05, 3'd3, rand32(), rand32());
      sendReg(7'h05, 3'd2, rand32(), rand32());
    end

    // Random encodings with gaps between requests
    testTag = "encoding";
    for (int k = 0; k < NumIllegal; k++) begin
      r = rand32();
      x = rand32();
      if (r[0]) sendImm(r[3:1], r[15:4], x);
      else sendOp(1'b0, r[3:1], r[10:4], r[15:11], x, {27'(rand32()), r[15:11]});
      idleCycles(1);
    end

    idleCycles(3);  // Drain the last response
    $display("Errors: %0d mismatches, %0d protocol", mismatchCount, protocolCount);
    if (mismatchCount == 0 && protocolCount == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// ==== sources.f ====
hw/rvConfigPkg.sv
hw/aluOpsPkg.sv
hw/shifter.sv
hw/zbbUnit.sv
hw/zbcUnit.sv
hw/aluDecoder.sv
hw/alu.sv
hw/executeStage.sv
verif/execChecker.sv
verif/tbExecute.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build the execute stage testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module tbExecute -f sources.f -o simExecute

out=$(./obj_dir/simExecute)
echo "$out"
grep -q "=== PASS ===" <<< "$out"
